// File: emesh_mem_stimulus.txt
# port write datamode ctrlmode dstaddr data srcaddr exp_data exp_srcaddr, all hex
# port 2 is a barrier, both ports drain before the next group starts
0 1 2 01 00000010 a5a51234 00000000 00000000 00000000
1 1 2 02 00000020 5a5a8765 00000000 00000000 00000000
0 1 2 00 000000a0 00000000 00000000 00000000 00000000
2 0 0 00 00000000 00000000 00000000 00000000 00000000
0 0 2 03 00000020 00000000 80000100 5a5a8765 00000020
1 0 2 04 00000010 00000000 90000200 a5a51234 00000010
0 1 0 00 00000040 00000011 00000000 00000000 00000000
0 1 0 00 00000041 00000022 00000000 00000000 00000000
0 1 0 00 00000042 00000033 00000000 00000000 00000000
0 1 0 00 00000043 00000044 00000000 00000000 00000000
1 1 1 00 00000048 0000beef 00000000 00000000 00000000
1 1 1 00 0000004a 0000cafe 00000000 00000000 00000000
1 1 0 00 0000004b 0000007e 00000000 00000000 00000000
2 0 0 00 00000000 00000000 00000000 00000000 00000000
0 0 2 05 00000040 00000000 a0000000 44332211 00000040
1 0 0 06 00000042 00000000 b0000000 00000033 00000042
0 0 1 07 0000004a 00000000 a0000004 00007efe 0000004a
1 0 2 08 00000048 00000000 b0000004 7efebeef 00000048
0 1 3 00 00000080 11112222 33334444 00000000 00000000
1 1 2 00 00000090 0badf00d 00000000 00000000 00000000
0 1 0 00 000000a0 000000aa 00000000 00000000 00000000
1 1 0 00 000000a3 000000bb 00000000 00000000 00000000
2 0 0 00 00000000 00000000 00000000 00000000 00000000
1 0 3 09 00000080 00000000 c0000000 11112222 33334444
0 0 2 0a 00000084 00000000 d0000000 33334444 00000084
0 0 2 0b 00000090 00000000 d0000008 0badf00d 00000090
1 0 2 0c 000000a0 00000000 c0000008 bb0000aa 000000a0

// File: filelist.f
emesh_pkg.sv
wb_pkg.sv
emesh2packet.sv
emesh_mem_port.sv
wb_arbiter.sv
wb_ram.sv
emesh_mem_top.sv
tb_clkgen.sv
emesh_mem_assertions.sv
emesh_mem_tb.sv

// File: run.sh
#!/bin/sh
# build and run the emesh memory testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --assert -f filelist.f --top-module emesh_mem_tb -o emesh_mem_sim

out=$(./obj_dir/emesh_mem_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -q "Simulation PASSED"; then
   exit 0
fi
exit 1

// File: emesh_mem_tb.sv
/*
 * emesh memory endpoint testbench
 * replays the stimulus file on both ports with random back-pressure
 */
module emesh_mem_tb
   import emesh_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam int MAX_LINES = 64;

   logic clk;
   logic rst_n;
   logic access_in_0;
   logic access_in_1;
   logic wait_in_0;
   logic wait_in_1;
   logic wait_out_0;
   logic wait_out_1;
   logic access_out_0;
   logic access_out_1;
   logic [PW-1:0] packet_in_0;
   logic [PW-1:0] packet_in_1;
   logic [PW-1:0] packet_out_0;
   logic [PW-1:0] packet_out_1;

   // stimulus columns
   logic [31:0] port_a [MAX_LINES];
   logic [31:0] wr_a [MAX_LINES];
   logic [31:0] dm_a [MAX_LINES];
   logic [31:0] cm_a [MAX_LINES];
   logic [31:0] dst_a [MAX_LINES];
   logic [31:0] dat_a [MAX_LINES];
   logic [31:0] src_a [MAX_LINES];
   logic [31:0] exp_dat_a [MAX_LINES];
   logic [31:0] exp_src_a [MAX_LINES];
   int          n_lines;
   int          err_count;
   logic [31:0] lfsr;

   tb_clkgen clkgen_i (.clk(clk), .rst_n(rst_n));

   emesh_mem_top #(.MEM_AW(8)) dut_i (.*);

   bind emesh_mem_top emesh_mem_assertions asrt_i (.*);

   // ############################################################
   // helpers
   // ############################################################

   task automatic abort_run(input string msg);
      $display("%s", msg);
      $display("Simulation FAILED");
      $fatal(1);
   endtask

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         err_count++;
         abort_run($sformatf("ERR %s got %h expected %h", name, got, exp));
      end
   endtask

   // taps 32 22 2 1
   function automatic logic lfsr_step_dummy_unused();
      return 1'b0;
   endfunction

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // high when two fresh bits are both one, about a quarter of the time
   function automatic logic pick_wait();
      logic a;
      lfsr = lfsr_step(lfsr);
      a    = lfsr[0];
      lfsr = lfsr_step(lfsr);
      return a & lfsr[0];
   endfunction

   task automatic drive_req(input int p, input logic acc, input logic [PW-1:0] pkt);
      if (p == 0)
      begin
         access_in_0 = acc;
         packet_in_0 = pkt;
      end
      else
      begin
         access_in_1 = acc;
         packet_in_1 = pkt;
      end
   endtask

   task automatic set_wait_in(input int p, input logic w);
      if (p == 0)
         wait_in_0 = w;
      else
         wait_in_1 = w;
   endtask

   function automatic logic get_wait_out(input int p);
      return (p == 0) ? wait_out_0 : wait_out_1;
   endfunction

   function automatic logic get_access_out(input int p);
      return (p == 0) ? access_out_0 : access_out_1;
   endfunction

   // ############################################################
   // per-port driver
   // ############################################################

   task automatic run_port(input int p, input int lo, input int hi);
      emesh_packet_u req;
      emesh_packet_u rsp;
      logic          taken;
      logic          w;
      for (int i = lo; i < hi; i++)
      begin
         if (port_a[i] == p)
         begin
            req                = '0;
            req.single.write   = wr_a[i][0];
            req.single.datamode = dm_a[i][1:0];
            req.single.ctrlmode = cm_a[i][4:0];
            req.single.dstaddr = dst_a[i];
            req.single.data    = dat_a[i];
            req.single.srcaddr = src_a[i];
            @(negedge clk);
            drive_req(p, 1'b1, req);
            while (get_wait_out(p))
               @(negedge clk);
            @(negedge clk);
            drive_req(p, 1'b0, '0);
            if (wr_a[i][0])
            begin
               // a write never raises a response while it runs
               while (get_wait_out(p))
               begin
                  check("access_out", 32'(get_access_out(p)), 32'h0);
                  @(negedge clk);
               end
            end
            else
            begin
               taken = 1'b0;
               while (!taken)
               begin
                  w = pick_wait();
                  set_wait_in(p, w);
                  if (get_access_out(p) && !w)
                  begin
                     rsp   = (p == 0) ? packet_out_0 : packet_out_1;
                     taken = 1'b1;
                  end
                  @(negedge clk);
               end
               set_wait_in(p, 1'b0);
               check("packet_out.write", 32'(rsp.single.write), 32'h1);
               check("packet_out.datamode", 32'(rsp.single.datamode), dm_a[i]);
               check("packet_out.ctrlmode", 32'(rsp.single.ctrlmode), cm_a[i]);
               check("packet_out.dstaddr", rsp.single.dstaddr, src_a[i]);
               check("packet_out.data", rsp.single.data, exp_dat_a[i]);
               check("packet_out.srcaddr", rsp.single.srcaddr, exp_src_a[i]);
            end
         end
      end
   endtask

   // ############################################################
   // main sequence
   // ############################################################

   initial
   begin
      int    fd;
      int    cnt;
      int    idx;
      int    seg_end;
      string line;
      access_in_0 = 1'b0;
      access_in_1 = 1'b0;
      packet_in_0 = '0;
      packet_in_1 = '0;
      wait_in_0   = 1'b0;
      wait_in_1   = 1'b0;
      err_count   = 0;
      n_lines     = 0;
      lfsr        = 32'hf9f3_038e;

      fd = $fopen("emesh_mem_stimulus.txt", "r");
      if (fd == 0)
         abort_run("could not open the stimulus file");
      while (!$feof(fd) && n_lines < MAX_LINES)
      begin
         line = "";
         cnt  = $fgets(line, fd);
         if (line.len() > 1 && line[0] != 8'h23)
         begin
            cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h", port_a[n_lines],
               wr_a[n_lines], dm_a[n_lines], cm_a[n_lines], dst_a[n_lines],
               dat_a[n_lines], src_a[n_lines], exp_dat_a[n_lines], exp_src_a[n_lines]);
            if (cnt == 9)
               n_lines++;
         end
      end
      $fclose(fd);
      if (n_lines == 0)
         abort_run("the stimulus file holds no transactions");

      // watchdog sized from the stimulus length
      fork
         begin
            #((n_lines * 60 + 20) * 8);
            abort_run("run timed out waiting for the DUT");
         end
      join_none

      @(posedge rst_n);
      @(negedge clk);
      check("access_out_0", 32'(access_out_0), 32'h0);
      check("access_out_1", 32'(access_out_1), 32'h0);
      check("wait_out_0", 32'(wait_out_0), 32'h0);
      check("wait_out_1", 32'(wait_out_1), 32'h0);

      // port 2 lines split the file into groups run on both ports at once
      idx = 0;
      while (idx < n_lines)
      begin
         seg_end = idx;
         while (seg_end < n_lines && port_a[seg_end] != 2)
            seg_end++;
         fork
            run_port(0, idx, seg_end);
            run_port(1, idx, seg_end);
         join
         idx = seg_end + 1;
      end

      @(negedge clk);
      if (err_count == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

// File: emesh_mem_assertions.sv
/*
 * bus and response protocol checks
 * bound into the memory endpoint top level
 */
module emesh_mem_assertions
   import emesh_pkg::*;
   import wb_pkg::*;
(
   input logic               clk,
   input logic               rst_n,
   input logic [N_PORTS-1:0] m_cyc,
   input logic [N_PORTS-1:0] m_stb,
   input logic [N_PORTS-1:0] m_ack,
   input logic               s_cyc,
   input logic               s_stb,
   input logic               s_ack,
   input logic               access_out_0,
   input logic [PW-1:0]      packet_out_0,
   input logic               wait_in_0,
   input logic               access_out_1,
   input logic [PW-1:0]      packet_out_1,
   input logic               wait_in_1
);

   timeunit 1ns;
   timeprecision 100ps;

   // stb only inside a cycle
   stb_in_cyc: assert property (@(posedge clk) disable iff (!rst_n)
      ((m_stb & ~m_cyc) == '0) && (!s_stb || s_cyc)) else $error("stb without cyc");

   // ack reaches one master at most
   one_grant: assert property (@(posedge clk) disable iff (!rst_n)
      $onehot0(m_ack)) else $error("ack routed to more than one master");

   ack_in_stb: assert property (@(posedge clk) disable iff (!rst_n)
      ((m_ack & ~m_stb) == '0) && (!s_ack || s_stb)) else $error("ack outside stb");

   // held response must not move
   hold_0: assert property (@(posedge clk) disable iff (!rst_n)
      access_out_0 && wait_in_0 |=> $stable(packet_out_0)) else $error("port 0 response moved");

   hold_1: assert property (@(posedge clk) disable iff (!rst_n)
      access_out_1 && wait_in_1 |=> $stable(packet_out_1)) else $error("port 1 response moved");

endmodule

// File: tb_clkgen.sv
/*
 * testbench clock and reset
 * 8 ns clock, reset held low for the first 10 cycles
 */
module tb_clkgen
(
   output logic clk,
   output logic rst_n
);

   timeunit 1ns;
   timeprecision 100ps;

   initial
   begin
      clk = 1'b0;
      forever
         #4 clk = ~clk;
   end

   // release away from the active edge
   initial
   begin
      rst_n = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;
   end

endmodule

// File: emesh_mem_top.sv
/*
 * emesh memory endpoint
 * two emesh ports sharing one wishbone ram through a round-robin arbiter
 */
module emesh_mem_top
   import emesh_pkg::*;
   import wb_pkg::*;
#(
   parameter int MEM_AW = 8
)
(
   input  logic          clk,
   input  logic          rst_n,
   // port 0
   input  logic          access_in_0,
   input  logic [PW-1:0] packet_in_0,
   output logic          wait_out_0,
   output logic          access_out_0,
   output logic [PW-1:0] packet_out_0,
   input  logic          wait_in_0,
   // port 1
   input  logic          access_in_1,
   input  logic [PW-1:0] packet_in_1,
   output logic          wait_out_1,
   output logic          access_out_1,
   output logic [PW-1:0] packet_out_1,
   input  logic          wait_in_1
);

   // ############################################################
   // master side buses, one entry per port
   // ############################################################

   logic [N_PORTS-1:0]            m_cyc;
   logic [N_PORTS-1:0]            m_stb;
   logic [N_PORTS-1:0]            m_we;
   logic [N_PORTS-1:0]            m_ack;
   logic [N_PORTS-1:0][WB_DW-1:0] m_adr;
   logic [N_PORTS-1:0][WB_DW-1:0] m_dat_w;
   logic [N_PORTS-1:0][WB_DW-1:0] m_dat_r;
   logic [N_PORTS-1:0][WB_SW-1:0] m_sel;

   // slave side
   logic             s_cyc;
   logic             s_stb;
   logic             s_we;
   logic             s_ack;
   logic [WB_DW-1:0] s_adr;
   logic [WB_DW-1:0] s_dat_w;
   logic [WB_DW-1:0] s_dat_r;
   logic [WB_SW-1:0] s_sel;

   emesh_mem_port #(.MEM_AW(MEM_AW)) port0_i (
      .clk (clk), .rst_n (rst_n),
      .access_in (access_in_0), .packet_in (packet_in_0), .wait_out (wait_out_0),
      .access_out (access_out_0), .packet_out (packet_out_0), .wait_in (wait_in_0),
      .wb_cyc (m_cyc[0]), .wb_stb (m_stb[0]), .wb_we (m_we[0]), .wb_adr (m_adr[0]),
      .wb_dat_w (m_dat_w[0]), .wb_sel (m_sel[0]),
      .wb_dat_r (m_dat_r[0]), .wb_ack (m_ack[0])
   );

   emesh_mem_port #(.MEM_AW(MEM_AW)) port1_i (
      .clk (clk), .rst_n (rst_n),
      .access_in (access_in_1), .packet_in (packet_in_1), .wait_out (wait_out_1),
      .access_out (access_out_1), .packet_out (packet_out_1), .wait_in (wait_in_1),
      .wb_cyc (m_cyc[1]), .wb_stb (m_stb[1]), .wb_we (m_we[1]), .wb_adr (m_adr[1]),
      .wb_dat_w (m_dat_w[1]), .wb_sel (m_sel[1]),
      .wb_dat_r (m_dat_r[1]), .wb_ack (m_ack[1])
   );

   wb_arbiter arb_i (
      .clk (clk), .rst_n (rst_n),
      .m_cyc (m_cyc), .m_stb (m_stb), .m_we (m_we), .m_adr (m_adr),
      .m_dat_w (m_dat_w), .m_sel (m_sel), .m_dat_r (m_dat_r), .m_ack (m_ack),
      .s_cyc (s_cyc), .s_stb (s_stb), .s_we (s_we), .s_adr (s_adr),
      .s_dat_w (s_dat_w), .s_sel (s_sel), .s_dat_r (s_dat_r), .s_ack (s_ack)
   );

   // ports already mask the word address to the ram size
   wb_ram #(.MEM_AW(MEM_AW)) ram_i (
      .clk (clk), .rst_n (rst_n),
      .cyc (s_cyc), .stb (s_stb), .we (s_we), .adr (s_adr[MEM_AW-1:0]),
      .dat_w (s_dat_w), .sel (s_sel), .dat_r (s_dat_r), .ack (s_ack)
   );

endmodule

// File: wb_ram.sv
/*
 * wishbone classic ram slave
 * one word per address, byte-lane writes, registered ack one cycle after stb
 */
module wb_ram
   import wb_pkg::*;
#(
   parameter int MEM_AW = 8
)
(
   input  logic              clk,
   input  logic              rst_n,
   input  logic              cyc,
   input  logic              stb,
   input  logic              we,
   input  logic [MEM_AW-1:0] adr,
   input  logic [WB_DW-1:0]  dat_w,
   input  logic [WB_SW-1:0]  sel,
   output logic [WB_DW-1:0]  dat_r,
   output logic              ack
);

   logic [WB_DW-1:0] mem [2**MEM_AW];
   logic             req;

   // new request, not the cycle already being acked
   assign req = cyc && stb && !ack;

   // single ack per beat
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
         ack <= 1'b0;
      else
         ack <= req;
   end

   // write lanes, or read word valid with ack
   always_ff @(posedge clk)
   begin
      if (req)
      begin
         if (we)
         begin
            for (int i = 0; i < WB_SW; i++)
               if (sel[i])
                  mem[adr][8*i +: 8] <= dat_w[8*i +: 8];
         end
         else
            dat_r <= mem[adr];
      end
   end

endmodule

// File: wb_arbiter.sv
/*
 * wishbone classic arbiter
 * round-robin grant of N_PORTS masters onto one slave, held for the whole cycle
 */
module wb_arbiter
   import wb_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst_n,
   // masters
   input  logic [N_PORTS-1:0]              m_cyc,
   input  logic [N_PORTS-1:0]              m_stb,
   input  logic [N_PORTS-1:0]              m_we,
   input  logic [N_PORTS-1:0][WB_DW-1:0]   m_adr,
   input  logic [N_PORTS-1:0][WB_DW-1:0]   m_dat_w,
   input  logic [N_PORTS-1:0][WB_SW-1:0]   m_sel,
   output logic [N_PORTS-1:0][WB_DW-1:0]   m_dat_r,
   output logic [N_PORTS-1:0]              m_ack,
   // slave
   output logic                            s_cyc,
   output logic                            s_stb,
   output logic                            s_we,
   output logic [WB_DW-1:0]                s_adr,
   output logic [WB_DW-1:0]                s_dat_w,
   output logic [WB_SW-1:0]                s_sel,
   input  logic [WB_DW-1:0]                s_dat_r,
   input  logic                            s_ack
);

   localparam int IW = (N_PORTS > 1) ? $clog2(N_PORTS) : 1;

   logic [IW-1:0] grant_q;
   logic [IW-1:0] grant;
   logic [IW-1:0] rr_ptr;
   logic [IW-1:0] cand;
   logic [IW-1:0] next_ptr;
   logic          found;

   // owner keeps the bus while its cyc is up
   // otherwise first requester from rr_ptr, combinationally
   always_comb
   begin
      grant = grant_q;
      cand  = grant_q;
      found = 1'b0;
      if (!m_cyc[grant_q])
      begin
         for (int i = 0; i < N_PORTS; i++)
         begin
            cand = IW'((int'(rr_ptr) + i) % N_PORTS);
            if (!found && m_cyc[cand])
            begin
               grant = cand;
               found = 1'b1;
            end
         end
      end
   end

   // priority moves past the current owner
   assign next_ptr = (grant == IW'(N_PORTS - 1)) ? '0 : grant + 1'b1;

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         grant_q <= '0;
         rr_ptr  <= '0;
      end
      else if (m_cyc[grant])
      begin
         grant_q <= grant;
         rr_ptr  <= next_ptr;
      end
   end

   // ############################################################
   // forwarding
   // ############################################################

   assign s_cyc   = m_cyc[grant];
   assign s_stb   = m_stb[grant];
   assign s_we    = m_we[grant];
   assign s_adr   = m_adr[grant];
   assign s_dat_w = m_dat_w[grant];
   assign s_sel   = m_sel[grant];

   // ack and read data back to the owner only
   always_comb
   begin
      for (int i = 0; i < N_PORTS; i++)
      begin
         m_ack[i]   = s_ack && (grant == IW'(i));
         m_dat_r[i] = (grant == IW'(i)) ? s_dat_r : '0;
      end
   end

endmodule

// File: emesh_mem_port.sv
/*
 * emesh memory port
 * takes one packet, runs one or two wishbone beats and returns a read response
 */
module emesh_mem_port
   import emesh_pkg::*;
   import wb_pkg::*;
#(
   parameter int MEM_AW = 8
)
(
   input  logic             clk,
   input  logic             rst_n,
   // emesh request side
   input  logic             access_in,
   input  logic [PW-1:0]    packet_in,
   output logic             wait_out,
   // emesh response side
   output logic             access_out,
   output logic [PW-1:0]    packet_out,
   input  logic             wait_in,
   // wishbone master
   output logic             wb_cyc,
   output logic             wb_stb,
   output logic             wb_we,
   output logic [WB_DW-1:0] wb_adr,
   output logic [WB_DW-1:0] wb_dat_w,
   output logic [WB_SW-1:0] wb_sel,
   input  logic [WB_DW-1:0] wb_dat_r,
   input  logic             wb_ack
);

   // ############################################################
   // state and request register
   // ############################################################

   localparam logic [1:0] S_IDLE  = 2'd0;
   localparam logic [1:0] S_BEAT  = 2'd1;
   localparam logic [1:0] S_BEAT2 = 2'd2;
   localparam logic [1:0] S_RESP  = 2'd3;

   logic [1:0]        state;
   logic              stb_q;
   emesh_packet_u     req_q;
   logic [WB_DW-1:0]  rd_lo;
   logic [WB_DW-1:0]  rd_hi;
   logic              take;
   logic              is_dbl;
   logic              beat_hi;
   logic              beat_done;
   logic [1:0]        off;
   logic [MEM_AW-1:0] word_adr;
   logic [WB_DW-1:0]  rd_lane;
   logic [AW-1:0]     rsp_src;

   // one request in flight, busy from the cycle after acceptance
   assign wait_out   = (state != S_IDLE);
   assign access_out = (state == S_RESP);
   assign take       = access_in && !wait_out;

   assign is_dbl    = (req_q.single.datamode == DM_DOUBLE);
   assign beat_hi   = (state == S_BEAT2);
   assign beat_done = stb_q && wb_ack;
   // byte lane offset within the word
   assign off       = req_q.single.dstaddr[1:0];

   // word address, second beat at a+1 within the ram
   assign word_adr = req_q.single.dstaddr[MEM_AW+1:2] + MEM_AW'(beat_hi);

   // ############################################################
   // wishbone master outputs
   // ############################################################

   assign wb_cyc = stb_q;
   assign wb_stb = stb_q;
   assign wb_we  = req_q.single.write;
   assign wb_adr = WB_DW'(word_adr);

   // lane replication and selects from datamode
   always_comb
   begin
      case (req_q.single.datamode)
         DM_BYTE:
         begin
            wb_dat_w = {4{req_q.single.data[7:0]}};
            wb_sel   = WB_SW'(4'b0001) << off;
         end
         DM_HALF:
         begin
            wb_dat_w = {2{req_q.single.data[15:0]}};
            wb_sel   = WB_SW'(4'b0011) << {off[1], 1'b0};
         end
         DM_DOUBLE:
         begin
            // double write carries its high word in the srcaddr slot
            wb_dat_w = beat_hi ? req_q.dbl.data_hi : req_q.dbl.data_lo;
            wb_sel   = '1;
         end
         default:
         begin
            wb_dat_w = req_q.single.data;
            wb_sel   = '1;
         end
      endcase
   end

   // read lanes down to bit 0, zero-extended
   always_comb
   begin
      case (req_q.single.datamode)
         DM_BYTE: rd_lane = WB_DW'(wb_dat_r[{off, 3'b000} +: 8]);
         DM_HALF: rd_lane = WB_DW'(wb_dat_r[{off[1], 4'b0000} +: 16]);
         default: rd_lane = wb_dat_r;
      endcase
   end

   // ############################################################
   // control FSM
   // ############################################################

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state <= S_IDLE;
         stb_q <= 1'b0;
      end
      else
      begin
         case (state)
            S_IDLE:
               if (take)
               begin
                  // first beat issued right away
                  state <= S_BEAT;
                  stb_q <= 1'b1;
               end
            S_BEAT:
               if (beat_done)
               begin
                  stb_q <= 1'b0;
                  if (is_dbl)
                     state <= S_BEAT2;
                  else
                     state <= req_q.single.write ? S_IDLE : S_RESP;
               end
            S_BEAT2:
               // idle cycle after the first ack, then second beat
               if (!stb_q)
                  stb_q <= 1'b1;
               else if (wb_ack)
               begin
                  stb_q <= 1'b0;
                  state <= req_q.single.write ? S_IDLE : S_RESP;
               end
            default:
               // response held until the mesh takes it
               if (!wait_in)
                  state <= S_IDLE;
         endcase
      end
   end

   // request and read data capture
   always_ff @(posedge clk)
   begin
      if (take)
         req_q <= packet_in;
      if (beat_done && !wb_we)
      begin
         if (beat_hi)
            rd_hi <= wb_dat_r;
         else
            rd_lo <= rd_lane;
      end
   end

   // ############################################################
   // read response
   // ############################################################

   // addresses swapped, high word in srcaddr slot for doubles
   assign rsp_src = is_dbl ? rd_hi : req_q.single.dstaddr;

   emesh2packet #(
      .AW (AW),
      .PW (PW)
   ) pack_i (
      .write    (1'b1),
      .datamode (req_q.single.datamode),
      .ctrlmode (req_q.single.ctrlmode),
      .dstaddr  (req_q.single.srcaddr),
      .data     (rd_lo),
      .srcaddr  (rsp_src),
      .packet   (packet_out)
   );

endmodule

// File: emesh2packet.sv
/*
 * emesh field packer
 * places write, datamode, ctrlmode and addresses into a 72 or 104 bit packet
 */
module emesh2packet
#(
   parameter int AW = 32,
   parameter int PW = 104
)
(
   input  logic          write,
   input  logic [1:0]    datamode,
   input  logic [4:0]    ctrlmode,
   input  logic [AW-1:0] dstaddr,
   input  logic [AW-1:0] data,
   input  logic [AW-1:0] srcaddr,
   output logic [PW-1:0] packet
);

   // control byte, common to every width
   assign packet[0]   = write;
   assign packet[2:1] = datamode;
   assign packet[7:3] = ctrlmode;

   generate
      if (PW == 104)
      begin : p104
         assign packet[39:8]   = dstaddr[31:0];
         assign packet[71:40]  = data[31:0];
         // return address, or high data word of a double
         assign packet[103:72] = srcaddr[31:0];
      end
      else if (PW == 72)
      begin : p72
         // no room for a source address here
         assign packet[39:8]  = dstaddr[31:0];
         assign packet[71:40] = data[31:0];
      end
      else
      begin : p_bad
         $error("emesh2packet: packet width %0d not supported", PW);
      end
   endgenerate

endmodule

// File: wb_pkg.sv
/*
 * wishbone bus constants
 * data and byte-select widths and the number of requesters on the shared ram
 */
package wb_pkg;

   // ############################################################
   // bus widths
   // ############################################################

   // one ram word per beat
   localparam int WB_DW = 32;
   // one select per byte lane
   localparam int WB_SW = WB_DW / 8;

   // emesh ports sharing the memory
   localparam int N_PORTS = 2;

endpackage

// File: emesh_pkg.sv
/*
 * emesh packet definitions
 * field layout of the 104-bit packet, datamode codes and the packet view type
 */
package emesh_pkg;

   // ############################################################
   // widths
   // ############################################################

   // address and data width of one emesh field
   localparam int AW = 32;
   // packet width carried on the ports
   localparam int PW = 104;
   // control field widths in the low byte
   localparam int DM_W = 2;
   localparam int CM_W = 5;

   // ############################################################
   // datamode codes
   // ############################################################

   localparam logic [DM_W-1:0] DM_BYTE   = 2'd0;
   localparam logic [DM_W-1:0] DM_HALF   = 2'd1;
   localparam logic [DM_W-1:0] DM_WORD   = 2'd2;
   localparam logic [DM_W-1:0] DM_DOUBLE = 2'd3;

   // ############################################################
   // packet views
   // ############################################################

   // low 40 bits identical in both views
   // upper two words are data/srcaddr, or data lo/hi for a double write
   typedef union packed
   {
      struct packed
      {
         logic [AW-1:0]   srcaddr;
         logic [AW-1:0]   data;
         logic [AW-1:0]   dstaddr;
         logic [CM_W-1:0] ctrlmode;
         logic [DM_W-1:0] datamode;
         logic            write;
      } single;
      struct packed
      {
         logic [AW-1:0]   data_hi;
         logic [AW-1:0]   data_lo;
         logic [AW-1:0]   dstaddr;
         logic [CM_W-1:0] ctrlmode;
         logic [DM_W-1:0] datamode;
         logic            write;
      } dbl;
   } emesh_packet_u;

endpackage
